//--- rtl/cop_mem_pkg.sv
// ======================================================================
// Shared definitions for the coprocessor load/store unit: subclass
// codes, the two views of the instruction word and the beat states.
// Other files refer to these by scoped names.
// ======================================================================

package cop_mem_pkg;

    localparam int DATA_W = 32;  // Bus and register width

    // Load/store subclasses; codes 10 to 15 are illegal
    typedef enum logic [3:0] {
        SC_LW        = 4'd0,
        SC_LH        = 4'd1,
        SC_LB        = 4'd2,
        SC_SW        = 4'd3,
        SC_SH        = 4'd4,
        SC_SB        = 4'd5,
        SC_GATHER_B  = 4'd6,
        SC_GATHER_H  = 4'd7,
        SC_SCATTER_B = 4'd8,
        SC_SCATTER_H = 4'd9
    } sclass_e;

    // Single access view
    typedef struct packed {
        sclass_e            subclass;
        logic [3:0]         rd;
        logic               wb_h;      // Destination halfword
        logic               wb_b;      // Destination byte in that half
        logic signed [11:0] imm;
        logic [9:0]         rsvd;
    } cop_instr_single_s;

    // Scatter/gather view
    typedef struct packed {
        sclass_e     subclass;
        logic [3:0]  rd;
        logic [1:0]  scale;            // Left shift of each lane offset
        logic [21:0] rsvd;
    } cop_instr_sg_s;

    typedef union packed {
        cop_instr_single_s single;
        cop_instr_sg_s     sg;
    } cop_instr_u;

    // Beat currently addressed by the sequencer
    typedef enum logic [2:0] {
        BEAT_IDLE = 3'd0,              // Also the first beat of any access
        BEAT_H1   = 3'd1,
        BEAT_B1   = 3'd2,
        BEAT_B2   = 3'd3,
        BEAT_B3   = 3'd4
    } beat_e;

endpackage

//--- rtl/cop_mem_decode.sv
// ======================================================================
// Instruction queue of the load/store unit. Entries arrive under
// credit flow control and one credit returns per pop. The head entry
// is decoded through the union view its subclass selects.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_decode #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic                                instr_valid,
    input  cop_mem_pkg::cop_instr_u             instr,
    input  logic [cop_mem_pkg::DATA_W-1:0]      gpr_rs1,
    input  logic [cop_mem_pkg::DATA_W-1:0]      cpr_rs2,
    input  logic                                dec_take,
    output logic                                instr_credit,
    output logic                                dec_valid,
    output cop_mem_pkg::sclass_e                dec_sclass,
    output logic [3:0]                          dec_rd,
    output logic                                dec_wb_h,
    output logic                                dec_wb_b,
    output logic [31:0]                         dec_offset,
    output logic [cop_mem_pkg::DATA_W-1:0]      dec_rs1,
    output logic [cop_mem_pkg::DATA_W-1:0]      dec_rs2
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    cop_mem_pkg::cop_instr_u            q_instr [QUEUE_DEPTH];
    logic [cop_mem_pkg::DATA_W-1:0]     q_rs1   [QUEUE_DEPTH];
    logic [cop_mem_pkg::DATA_W-1:0]     q_rs2   [QUEUE_DEPTH];
    logic [PTR_W-1:0]                   wr_ptr, rd_ptr;
    logic [CNT_W-1:0]                   count;
    logic                               push, pop, full;
    cop_mem_pkg::cop_instr_u            head;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push         = instr_valid;
    assign pop          = dec_take && dec_valid;
    assign full         = count == CNT_W'(QUEUE_DEPTH);
    assign instr_credit = pop;              // Credit back as the entry leaves

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) begin
            q_instr[wr_ptr] <= instr;
            q_rs1[wr_ptr]   <= gpr_rs1;
            q_rs2[wr_ptr]   <= cpr_rs2;
        end
    end

    // Head decode
    assign head       = q_instr[rd_ptr];
    assign dec_valid  = count != '0;
    assign dec_sclass = head.single.subclass;
    assign dec_rd     = head.single.rd;
    assign dec_wb_h   = head.single.wb_h;
    assign dec_wb_b   = head.single.wb_b;
    assign dec_rs1    = q_rs1[rd_ptr];
    assign dec_rs2    = q_rs2[rd_ptr];
    assign dec_offset = (head.single.subclass <= cop_mem_pkg::SC_SB) ?
                        {{20{head.single.imm[11]}}, head.single.imm} :
                        {30'b0, head.sg.scale};

    // Issuer must respect its credits
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        push |-> !full || pop);

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        push |-> instr.single.subclass inside
            {[cop_mem_pkg::SC_LW : cop_mem_pkg::SC_SCATTER_H]});

endmodule

//--- rtl/cop_mem_access.sv
// ======================================================================
// Beat sequencer of the load/store unit. Forms each beat's address,
// drives the word memory port, flags misalignment and bus errors and
// reports every accepted beat and finished instruction to the result.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_access #(
    parameter int ADDR_W = 32
) (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            dec_valid,
    input  cop_mem_pkg::sclass_e            dec_sclass,
    input  logic [3:0]                      dec_rd,
    input  logic                            dec_wb_h,
    input  logic                            dec_wb_b,
    input  logic [31:0]                     dec_offset,
    input  logic [cop_mem_pkg::DATA_W-1:0]  dec_rs1,
    input  logic [cop_mem_pkg::DATA_W-1:0]  dec_rs2,
    input  logic                            mem_stall,
    input  logic                            mem_error,
    output logic                            dec_take,
    output logic                            mem_cen,
    output logic                            mem_wen,
    output logic [ADDR_W-1:0]               mem_addr,
    output logic [cop_mem_pkg::DATA_W-1:0]  mem_wdata,
    output logic [3:0]                      mem_ben,
    output logic                            beat_done,
    output logic [1:0]                      beat_lane,
    output logic [1:0]                      beat_lsbs,
    output logic                            beat_half,
    output logic                            ins_done,
    output logic [3:0]                      ins_rd,
    output logic                            ins_load,
    output logic                            addr_error,
    output logic                            bus_error
);
    localparam int DW = cop_mem_pkg::DATA_W;

    cop_mem_pkg::beat_e state, adv, drv_state;
    logic               is_single, is_word, is_half, is_sg_h;
    logic               pending, accept, last, want, misaligned;
    logic [1:0]         p_lsbs, drv_idx, pend_idx, drv_lane;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;
    logic [DW-1:0]      offset;
    logic [ADDR_W-1:0]  addr;

    function automatic logic [1:0] beat_idx(input cop_mem_pkg::beat_e s);
        case (s)
            cop_mem_pkg::BEAT_H1, cop_mem_pkg::BEAT_B1: beat_idx = 2'd1;
            cop_mem_pkg::BEAT_B2:                       beat_idx = 2'd2;
            cop_mem_pkg::BEAT_B3:                       beat_idx = 2'd3;
            default:                                    beat_idx = 2'd0;
        endcase
    endfunction

    assign is_single = dec_sclass <= cop_mem_pkg::SC_SB;
    assign is_word   = dec_sclass inside {cop_mem_pkg::SC_LW, cop_mem_pkg::SC_SW};
    assign is_sg_h   = dec_sclass inside {cop_mem_pkg::SC_GATHER_H, cop_mem_pkg::SC_SCATTER_H};
    assign is_half   = is_sg_h || dec_sclass inside {cop_mem_pkg::SC_LH, cop_mem_pkg::SC_SH};
    assign ins_load  = dec_sclass inside {cop_mem_pkg::SC_LW, cop_mem_pkg::SC_LH,
        cop_mem_pkg::SC_LB, cop_mem_pkg::SC_GATHER_B, cop_mem_pkg::SC_GATHER_H};

    // Sequencer
    assign accept = pending && !mem_stall;
    assign last   = is_single || (is_sg_h ? state == cop_mem_pkg::BEAT_H1 :
                                            state == cop_mem_pkg::BEAT_B3);

    always_comb begin
        case (state)
            cop_mem_pkg::BEAT_IDLE: adv = is_sg_h ? cop_mem_pkg::BEAT_H1 : cop_mem_pkg::BEAT_B1;
            cop_mem_pkg::BEAT_B1:   adv = cop_mem_pkg::BEAT_B2;
            cop_mem_pkg::BEAT_B2:   adv = cop_mem_pkg::BEAT_B3;
            default:                adv = cop_mem_pkg::BEAT_IDLE;
        endcase
    end

    // Next beat goes out in the cycle the previous one is accepted
    assign want      = dec_valid && (!pending || (accept && !mem_error && !last));
    assign drv_state = accept ? adv : state;
    assign drv_idx   = beat_idx(drv_state);
    assign pend_idx  = beat_idx(state);
    assign drv_lane  = is_single ? {dec_wb_h, dec_wb_b} :
                       is_sg_h   ? {drv_idx[0], 1'b0}   : drv_idx;

    // Lane of rs2 is store data for singles, offset and data for scatter
    assign byte_sel = dec_rs2[8*drv_lane +: 8];
    assign half_sel = dec_rs2[16*drv_lane[1] +: 16];
    assign offset   = is_single ? dec_offset :
                      (is_sg_h ? DW'(half_sel) : DW'(byte_sel)) << dec_offset[1:0];
    assign addr     = dec_rs1[ADDR_W-1:0] + offset[ADDR_W-1:0];

    assign misaligned = is_word ? |addr[1:0] : is_half && addr[0];
    assign addr_error = want && misaligned;             // No bus cycle raised
    assign bus_error  = accept && mem_error;
    assign ins_done   = (accept && (mem_error || last)) || addr_error;
    assign dec_take   = ins_done;

    // Bus drive is held while stalled
    assign mem_cen   = (want && !misaligned) || (pending && mem_stall);
    assign mem_wen   = mem_cen && !ins_load;
    assign mem_addr  = {addr[ADDR_W-1:2], 2'b00};
    assign mem_wdata = is_word ? dec_rs2 : is_half ? {half_sel, half_sel} : {4{byte_sel}};
    assign mem_ben   = is_word ? 4'hf : is_half ? (addr[1] ? 4'hc : 4'h3) : 4'b1 << addr[1:0];

    // Beat report; a half with an odd lane marks a full word
    assign beat_done = accept;
    assign beat_lsbs = p_lsbs;
    assign beat_half = is_half || is_word;
    assign beat_lane = is_word   ? 2'b01 :
                       is_single ? {dec_wb_h, dec_wb_b && !is_half} :
                       is_sg_h   ? {pend_idx[0], 1'b0} : pend_idx;
    assign ins_rd    = dec_rd;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state   <= cop_mem_pkg::BEAT_IDLE;
            pending <= 1'b0;
        end else begin
            pending <= mem_cen;
            if (ins_done)
                state <= cop_mem_pkg::BEAT_IDLE;
            else if (accept)
                state <= adv;
        end
    end

    always_ff @(posedge g_clk) begin
        if (want) p_lsbs <= addr[1:0];      // Low bits of the beat in flight
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        pending && mem_stall |-> $stable(mem_addr) && $stable(mem_wdata));

endmodule

//--- rtl/cop_mem_result.sv
// ======================================================================
// Result stage of the load/store unit. Steers loaded bytes and halves
// into their destination lanes, gathers byte enables over the beats
// and registers one writeback and completion per instruction.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_result (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic [cop_mem_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                            beat_done,
    input  logic [1:0]                      beat_lane,
    input  logic [1:0]                      beat_lsbs,
    input  logic                            beat_half,
    input  logic                            ins_done,
    input  logic [3:0]                      ins_rd,
    input  logic                            ins_load,
    input  logic                            addr_error,
    input  logic                            bus_error,
    output logic                            res_valid,
    output logic [3:0]                      res_rd,
    output logic [3:0]                      res_ben,
    output logic [cop_mem_pkg::DATA_W-1:0]  res_wdata,
    output logic                            res_addr_error,
    output logic                            res_bus_error,
    output logic                            res_store
);
    localparam int DW = cop_mem_pkg::DATA_W;

    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    logic [3:0]    new_ben, cur_ben, acc_ben;
    logic [DW-1:0] rep, ben_mask, cur_data, acc_data;
    logic          take, ok;

    assign ld_byte = mem_rdata[8*beat_lsbs +: 8];
    assign ld_half = mem_rdata[16*beat_lsbs[1] +: 16];
    assign take    = beat_done && ins_load;
    assign ok      = !(addr_error || bus_error);

    // Replicate then keep only the destination lanes
    always_comb begin
        if (beat_half && beat_lane[0]) begin
            new_ben = 4'hf;
            rep     = mem_rdata;
        end else if (beat_half) begin
            new_ben = beat_lane[1] ? 4'hc : 4'h3;
            rep     = {ld_half, ld_half};
        end else begin
            new_ben = 4'b1 << beat_lane;
            rep     = {4{ld_byte}};
        end
        cur_ben = take ? new_ben : 4'h0;
        for (int i = 0; i < 4; i++)
            ben_mask[8*i +: 8] = {8{cur_ben[i]}};
        cur_data = rep & ben_mask;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            res_valid <= 1'b0;
            acc_ben   <= 4'h0;
            acc_data  <= '0;
        end else begin
            res_valid <= ins_done;
            if (ins_done) begin
                acc_ben  <= 4'h0;
                acc_data <= '0;
            end else begin
                acc_ben  <= acc_ben | cur_ben;
                acc_data <= acc_data | cur_data;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (ins_done) begin
            res_rd         <= ins_rd;
            res_store      <= !ins_load;
            res_addr_error <= addr_error;
            res_bus_error  <= bus_error;
            res_ben        <= ok ? (acc_ben | cur_ben) : 4'h0;   // Errors drop all beats
            res_wdata      <= ok ? (acc_data | cur_data) : '0;
        end
    end

endmodule

//--- rtl/cop_mem_top.sv
// ======================================================================
// Load/store unit of the cryptographic coprocessor. Takes credited
// instructions, runs their beats on a word memory port and returns
// one writeback and completion per instruction, in issue order.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_top #(
    parameter int QUEUE_DEPTH = 2,
    parameter int ADDR_W      = 32
) (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            instr_valid,
    input  cop_mem_pkg::cop_instr_u         instr,
    input  logic [cop_mem_pkg::DATA_W-1:0]  gpr_rs1,
    input  logic [cop_mem_pkg::DATA_W-1:0]  cpr_rs2,
    output logic                            instr_credit,
    output logic                            mem_cen,
    output logic                            mem_wen,
    output logic [ADDR_W-1:0]               mem_addr,
    output logic [cop_mem_pkg::DATA_W-1:0]  mem_wdata,
    output logic [3:0]                      mem_ben,
    input  logic [cop_mem_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                            mem_stall,
    input  logic                            mem_error,
    output logic                            res_valid,
    output logic [3:0]                      res_rd,
    output logic [3:0]                      res_ben,
    output logic [cop_mem_pkg::DATA_W-1:0]  res_wdata,
    output logic                            res_addr_error,
    output logic                            res_bus_error,
    output logic                            res_store
);
    logic                               dec_valid, dec_take, dec_wb_h, dec_wb_b;
    cop_mem_pkg::sclass_e               dec_sclass;
    logic [3:0]                         dec_rd, ins_rd;
    logic [31:0]                        dec_offset;
    logic [cop_mem_pkg::DATA_W-1:0]     dec_rs1, dec_rs2;
    logic                               beat_done, beat_half, ins_done, ins_load;
    logic [1:0]                         beat_lane, beat_lsbs;
    logic                               addr_error, bus_error;

    cop_mem_decode #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_decode (
        .g_clk, .g_resetn, .instr_valid, .instr, .gpr_rs1, .cpr_rs2, .dec_take,
        .instr_credit, .dec_valid, .dec_sclass, .dec_rd, .dec_wb_h, .dec_wb_b,
        .dec_offset, .dec_rs1, .dec_rs2
    );

    cop_mem_access #(.ADDR_W(ADDR_W)) u_access (
        .g_clk, .g_resetn, .dec_valid, .dec_sclass, .dec_rd, .dec_wb_h, .dec_wb_b,
        .dec_offset, .dec_rs1, .dec_rs2, .mem_stall, .mem_error, .dec_take,
        .mem_cen, .mem_wen, .mem_addr, .mem_wdata, .mem_ben, .beat_done,
        .beat_lane, .beat_lsbs, .beat_half, .ins_done, .ins_rd, .ins_load,
        .addr_error, .bus_error
    );

    cop_mem_result u_result (
        .g_clk, .g_resetn, .mem_rdata, .beat_done, .beat_lane, .beat_lsbs,
        .beat_half, .ins_done, .ins_rd, .ins_load, .addr_error, .bus_error,
        .res_valid, .res_rd, .res_ben, .res_wdata, .res_addr_error,
        .res_bus_error, .res_store
    );

endmodule

//--- verif/cop_mem_ram.sv
// ======================================================================
// Word memory model for the load/store unit testbench. Each request
// sees 0 to 3 random stall cycles and any access to one marked word
// returns an error. Stores write the enabled bytes.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_ram #(
    parameter logic [31:0] ERR_ADDR = 32'h0000_0ff0
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        mem_cen,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_ben,
    output logic [31:0] mem_rdata,
    output logic        mem_stall,
    output logic        mem_error
);
    logic [7:0]  mem [4096];
    logic [31:0] lcg_state;
    logic [31:0] req_addr;
    logic [1:0]  stall_cnt;
    logic        busy;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // XOR fold of the address with 5a gives the low byte rule below 0x100
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        fill_byte = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    initial begin
        for (int a = 0; a < 4096; a++)
            mem[a] = fill_byte(32'(a));
    end

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            busy      <= 1'b0;
            stall_cnt <= 2'd0;
            req_addr  <= '0;
            lcg_state <= 32'h23b5_6cef;
        end else if (busy && stall_cnt != 2'd0) begin
            stall_cnt <= stall_cnt - 2'd1;          // Request held by the DUT
        end else begin
            busy <= mem_cen;
            if (mem_cen) begin
                req_addr  <= mem_addr;
                stall_cnt <= lcg_state[17:16];
                lcg_state <= lcg_next(lcg_state);
                if (mem_wen && mem_addr != ERR_ADDR) begin
                    for (int i = 0; i < 4; i++)
                        if (mem_ben[i])
                            mem[{mem_addr[11:2], 2'(i)}] <= mem_wdata[8*i +: 8];
                end
            end
        end
    end

    assign mem_stall = busy && stall_cnt != 2'd0;
    assign mem_error = busy && req_addr == ERR_ADDR;   // Any access to the marked word
    assign mem_rdata = {mem[{req_addr[11:2], 2'd3}], mem[{req_addr[11:2], 2'd2}],
                        mem[{req_addr[11:2], 2'd1}], mem[{req_addr[11:2], 2'd0}]};

endmodule

//--- verif/cop_mem_tb.sv
// ======================================================================
// Testbench for the coprocessor load/store unit. Issues every golden
// line back to back under issue credits, with random memory stalls,
// and checks each result in issue order against the golden file.
// ======================================================================
`timescale 1ns/100ps

module cop_mem_tb;
    localparam int QUEUE_DEPTH = 2;
    localparam int MAX_TESTS   = 64;

    logic                    g_clk, g_resetn, instr_valid, instr_credit;
    cop_mem_pkg::cop_instr_u instr;
    logic [31:0]             gpr_rs1, cpr_rs2, mem_addr, mem_wdata, mem_rdata, res_wdata;
    logic                    mem_cen, mem_wen, mem_stall, mem_error;
    logic [3:0]              mem_ben, res_rd, res_ben;
    logic                    res_valid, res_addr_error, res_bus_error, res_store;

    string       test_name  [MAX_TESTS];
    logic [31:0] stim_instr [MAX_TESTS];
    logic [31:0] stim_rs1   [MAX_TESTS];
    logic [31:0] stim_rs2   [MAX_TESTS];
    logic [31:0] exp_ben    [MAX_TESTS];
    logic [31:0] exp_wdata  [MAX_TESTS];
    logic [31:0] exp_aerr   [MAX_TESTS];
    logic [31:0] exp_berr   [MAX_TESTS];
    logic [31:0] chk_addr   [MAX_TESTS];       // ffffffff means no readback
    logic [31:0] chk_word   [MAX_TESTS];
    int          num_tests = 0;
    int          checked   = 0;
    int          issued;
    int          credits;

    cop_mem_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .ADDR_W(32)) UUT (
        .g_clk, .g_resetn, .instr_valid, .instr, .gpr_rs1, .cpr_rs2, .instr_credit,
        .mem_cen, .mem_wen, .mem_addr, .mem_wdata, .mem_ben, .mem_rdata, .mem_stall,
        .mem_error, .res_valid, .res_rd, .res_ben, .res_wdata, .res_addr_error,
        .res_bus_error, .res_store
    );

    cop_mem_ram ram (
        .g_clk, .g_resetn, .mem_cen, .mem_wen, .mem_addr, .mem_wdata, .mem_ben,
        .mem_rdata, .mem_stall, .mem_error
    );

    initial g_clk = 1'b0;
    always #50 g_clk = ~g_clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        string tok;
        string rest;
        fd = $fopen("verif/cop_mem_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open verif/cop_mem_golden.txt");
        end else begin
            while (num_tests < MAX_TESTS && $fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);          // Rest of a comment line
                end else begin
                    test_name[num_tests] = tok;
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", stim_instr[num_tests],
                                stim_rs1[num_tests], stim_rs2[num_tests], exp_ben[num_tests],
                                exp_wdata[num_tests], exp_aerr[num_tests], exp_berr[num_tests],
                                chk_addr[num_tests], chk_word[num_tests]);
                    if (n != 9)
                        abort_run({"Golden line is incomplete for test ", tok});
                    else
                        num_tests++;
                end
            end
            $fclose(fd);
            if (num_tests == 0)
                abort_run("Golden file holds no tests");
        end
    endtask

    // Rd and the store flag follow from the instruction word itself
    task automatic check_result(input int i);
        logic [11:0] a;
        logic [31:0] word;
        logic        store;
        store = stim_instr[i][31:28] inside {cop_mem_pkg::SC_SW, cop_mem_pkg::SC_SH,
            cop_mem_pkg::SC_SB, cop_mem_pkg::SC_SCATTER_B, cop_mem_pkg::SC_SCATTER_H};
        check_value({test_name[i], ".rd"}, 32'(stim_instr[i][27:24]), 32'(res_rd));
        check_value({test_name[i], ".store"}, 32'(store), 32'(res_store));
        check_value({test_name[i], ".ben"}, exp_ben[i], 32'(res_ben));
        check_value({test_name[i], ".wdata"}, exp_wdata[i], res_wdata);
        check_value({test_name[i], ".addr_error"}, exp_aerr[i], 32'(res_addr_error));
        check_value({test_name[i], ".bus_error"}, exp_berr[i], 32'(res_bus_error));
        if (chk_addr[i] != 32'hffff_ffff) begin
            a    = chk_addr[i][11:0];
            word = {ram.mem[{a[11:2], 2'd3}], ram.mem[{a[11:2], 2'd2}],
                    ram.mem[{a[11:2], 2'd1}], ram.mem[{a[11:2], 2'd0}]};
            check_value({test_name[i], ".mem"}, chk_word[i], word);
        end
    endtask

    // Results come back in issue order
    always @(negedge g_clk) begin
        if (g_resetn && res_valid) begin
            if (checked >= num_tests) begin
                abort_run("Result arrived with no instruction outstanding");
            end else begin
                check_result(checked);
                checked++;
            end
        end
    end

    initial begin
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        gpr_rs1     = '0;
        cpr_rs2     = '0;
        load_golden();
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        credits  = QUEUE_DEPTH;
        issued   = 0;
        while (issued < num_tests) begin
            @(negedge g_clk);
            if (instr_credit)
                credits++;
            if (credits > QUEUE_DEPTH)
                abort_run("More credits returned than instructions issued");
            instr_valid = 1'b0;
            if (credits > 0) begin          // Spend one credit per valid cycle
                instr_valid = 1'b1;
                instr       = stim_instr[issued];
                gpr_rs1     = stim_rs1[issued];
                cpr_rs2     = stim_rs2[issued];
                credits--;
                issued++;
            end
        end
        @(negedge g_clk);
        instr_valid = 1'b0;
        wait (checked == num_tests);
        @(negedge g_clk);
        $display("Verification passed");
        $finish;
    end

    // Watchdog allows 40 cycles per test plus reset
    initial begin
        wait (num_tests > 0);
        repeat ((num_tests + 1) * 40) @(posedge g_clk);
        abort_run($sformatf("Timed out with %0d of %0d results checked", checked, num_tests));
    end

endmodule

//--- verif/cop_mem_golden.txt
# name instr gpr_rs1 cpr_rs2 exp_ben exp_wdata exp_addr_error exp_bus_error chk_addr chk_word
# chk_addr ffffffff skips the memory readback, all values in hex
lw_base      01000000 00000040 00000000 f 19181b1a 0 0 ffffffff 00000000
lw_imm_neg   023fe000 00000050 00000000 f 11101312 0 0 ffffffff 00000000
lh_to_h0     13000000 00000044 00000000 3 00001f1e 0 0 ffffffff 00000000
lh_to_h1     14800800 00000044 00000000 c 1d1c0000 0 0 ffffffff 00000000
lb_to_b0     25000400 00000060 00000000 1 0000003b 0 0 ffffffff 00000000
lb_to_b1     25400800 00000060 00000000 2 00003800 0 0 ffffffff 00000000
lb_to_b2     25800c00 00000060 00000000 4 00390000 0 0 ffffffff 00000000
lb_to_b3     25c00000 00000060 00000000 8 3a000000 0 0 ffffffff 00000000
sw_word      30000000 00000080 deadbeef 0 00000000 0 0 00000080 deadbeef
lw_after_sw  01000000 00000080 00000000 f deadbeef 0 0 ffffffff 00000000
sh_upper     40800800 00000084 1234abcd 0 00000000 0 0 00000084 1234dfde
lw_after_sh  01000000 00000084 00000000 f 1234dfde 0 0 ffffffff 00000000
sb_lane1     50400400 00000088 11223344 0 00000000 0 0 00000088 d1d033d2
lw_after_sb  01000000 00000088 00000000 f d1d033d2 0 0 ffffffff 00000000
gather_b_s0  66000000 00000020 0310050c f 796a7f76 0 0 ffffffff 00000000
gather_b_s1  67400000 00000020 08040201 f 6a727e78 0 0 ffffffff 00000000
gather_h_s0  78000000 00000030 000a0004 f 61606f6e 0 0 ffffffff 00000000
gather_h_s1  79400000 00000030 00070001 f 65646968 0 0 ffffffff 00000000
scatter_b_s0 80000000 000000a0 0d0a0501 0 00000000 0 0 000000a4 fdfc05fe
gather_back  6a000000 000000a0 0d0a0501 f 0d0a0501 0 0 ffffffff 00000000
scatter_h_s1 90400000 000000c0 00050002 0 00000000 0 0 000000c8 00059392
lw_after_sch 0b000000 000000c4 00000000 f 9d9c0002 0 0 ffffffff 00000000
lw_misalign  0c000000 00000041 00000000 0 00000000 1 0 ffffffff 00000000
lh_misalign  1d000000 00000043 00000000 0 00000000 1 0 ffffffff 00000000
sw_misalign  30000000 00000091 ffffffff 0 00000000 1 0 00000090 c9c8cbca
gather_h_odd 7e000000 00000030 00030002 0 00000000 1 0 ffffffff 00000000
lw_bus_err   0f000000 00000ff0 00000000 0 00000000 0 1 ffffffff 00000000
gather_b_err 6f000000 00000f00 30f02010 0 00000000 0 1 ffffffff 00000000

//--- filelist.f
rtl/cop_mem_pkg.sv
rtl/cop_mem_decode.sv
rtl/cop_mem_access.sv
rtl/cop_mem_result.sv
rtl/cop_mem_top.sv
verif/cop_mem_ram.sv
verif/cop_mem_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -Wno-fatal -f filelist.f \
		--top-module cop_mem_tb -Mdir $(OBJ_DIR)

run: compile
	out=$$(./$(OBJ_DIR)/Vcop_mem_tb 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
